// ==== llm_int_cfg.svh ====
`ifndef LLM_INT_CFG_SVH
`define LLM_INT_CFG_SVH

// word width of the full-precision path, one input word
`define LLM_ORIG_PREC  16

// word width after quantization
`define LLM_RED_PREC   8

// vector length, which is also the side of the square weight matrix
`define LLM_DIM        4

// at most this many outliers per vector take the exact path
`define LLM_HIGH_SLOTS 2

// magnitude above which an input element counts as an outlier
`define LLM_THRESHOLD  1000

// default depth of the stream buffers
`define LLM_FIFO_DEPTH 2

`endif

// ==== llm_int_pkg.sv ====
`default_nettype none

`include "llm_int_cfg.svh"

package llm_int_pkg;

    // ########################################################################
    // derived widths
    // ########################################################################

    // quantization drops this many low bits by arithmetic shift
    localparam int LLM_QSHIFT = `LLM_ORIG_PREC - `LLM_RED_PREC;

    // a full product is twice the word width, plus headroom to sum one row
    localparam int LLM_ACC_W = 2 * `LLM_ORIG_PREC + $clog2(`LLM_DIM);

    // ########################################################################
    // stream payloads
    // ########################################################################

    typedef logic signed [`LLM_ORIG_PREC-1:0] word_t;
    typedef logic signed [`LLM_RED_PREC-1:0]  qword_t;
    typedef logic signed [LLM_ACC_W-1:0]      acc_t;

    typedef word_t [`LLM_DIM-1:0] vec_t;

    // an element is nonzero in at most one of the two lanes
    typedef struct packed {
        vec_t high;
        vec_t low;
    } split_t;

    // the first index is the row, which selects the output element
    typedef word_t  [`LLM_DIM-1:0][`LLM_DIM-1:0] wmat_t;
    typedef qword_t [`LLM_DIM-1:0][`LLM_DIM-1:0] qmat_t;

    typedef struct packed {
        wmat_t full;
        qmat_t quant;
    } weight_set_t;

    typedef acc_t [`LLM_DIM-1:0] acc_vec_t;

endpackage

`default_nettype wire

// ==== outlier_scatter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "llm_int_cfg.svh"

module outlier_scatter (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire llm_int_pkg::vec_t   in_data,
    input  wire logic                in_valid,
    output logic                     in_ready,
    output llm_int_pkg::split_t      out_data,
    output logic                     out_valid,
    input  wire logic                out_ready
);

    import llm_int_pkg::*;

    split_t split_d;

    // true when the word lies outside the symmetric threshold band
    function automatic logic is_outlier(word_t w);
        return ($signed(w) > `LLM_THRESHOLD) || ($signed(w) < -`LLM_THRESHOLD);
    endfunction

    // true when some position carries a nonzero word in both lanes
    function automatic logic lanes_clash(split_t s);
        logic clash;
        clash = 1'b0;
        for (int i = 0; i < `LLM_DIM; i++) begin
            clash = clash || ((s.high[i] != '0) && (s.low[i] != '0));
        end
        return clash;
    endfunction

    // ########################################################################
    // split
    // ########################################################################

    // high-lane slots are granted in index order, later outliers fall back
    // to the quantized lane
    always_comb begin
        int unsigned n_high;
        split_d = '0;
        n_high  = 0;
        for (int i = 0; i < `LLM_DIM; i++) begin
            if (is_outlier(in_data[i]) && (n_high < `LLM_HIGH_SLOTS)) begin
                split_d.high[i] = in_data[i];
                n_high++;
            end else begin
                split_d.low[i] = in_data[i];
            end
        end
    end

    // ########################################################################
    // output register
    // ########################################################################

    // the register takes a new vector when empty or when its content leaves
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= split_d;
        end
    end

    // the consumer adds both lanes, so a shared position would count twice
    a_lanes_disjoint: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> !lanes_clash(out_data)
    ) else $error("outlier_scatter: element present in both lanes");

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "llm_int_cfg.svh"

module stream_fifo #(
    parameter type payload_t = llm_int_pkg::vec_t,
    parameter int  DEPTH     = `LLM_FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire payload_t in_data,
    input  wire logic     in_valid,
    output logic          in_ready,
    output payload_t      out_data,
    output logic          out_valid,
    input  wire logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    logic refill;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ready comes from the count alone, so back-pressure never reaches the
    // write side in the same cycle
    assign in_ready = (count != CNT_W'(DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;

    // the output register takes a new head when empty or being drained
    assign refill = !out_valid || pop;

    // with nothing stored, a new word goes straight to the output register
    assign bypass = push && refill && (count == '0);
    assign mem_rd = refill && (count != '0);
    assign mem_wr = push && !bypass;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (mem_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (mem_wr && !mem_rd) begin
                count <= count + 1'b1;
            end else if (mem_rd && !mem_wr) begin
                count <= count - 1'b1;
            end
            if (refill) begin
                out_valid <= mem_rd || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_data;
        end
        if (mem_rd) begin
            out_data <= mem[rd_ptr];
        end else if (bypass) begin
            out_data <= in_data;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH)
    ) else $error("stream_fifo: storage count beyond depth");

    // a stalled head keeps its value until the consumer takes it
    a_stable_head: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("stream_fifo: head changed while stalled");

endmodule

`default_nettype wire

// ==== weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "llm_int_cfg.svh"

module weight_store (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire llm_int_pkg::wmat_t   w_data,
    input  wire logic                 w_valid,
    output logic                      w_ready,
    input  wire logic                 busy,
    output llm_int_pkg::weight_set_t  weights,
    output logic                      loaded
);

    import llm_int_pkg::*;

    qmat_t quant_d;
    logic  load;

    // a new matrix lands only while no vector is in flight downstream, so
    // one result never mixes two weight sets
    assign w_ready = !busy;
    assign load    = w_valid && w_ready;

    // quantized copy by plain arithmetic shift, no rounding
    always_comb begin
        for (int r = 0; r < `LLM_DIM; r++) begin
            for (int c = 0; c < `LLM_DIM; c++) begin
                quant_d[r][c] = qword_t'($signed(w_data[r][c]) >>> LLM_QSHIFT);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded <= 1'b0;
        end else if (load) begin
            loaded <= 1'b1;
        end
    end

    // both copies are held until the next load
    always_ff @(posedge clk) begin
        if (load) begin
            weights.full  <= w_data;
            weights.quant <= quant_d;
        end
    end

endmodule

`default_nettype wire

// ==== mixed_linear.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "llm_int_cfg.svh"

module mixed_linear (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire llm_int_pkg::split_t      in_data,
    input  wire logic                     in_valid,
    output logic                          in_ready,
    input  wire llm_int_pkg::weight_set_t weights,
    input  wire logic                     loaded,
    output logic                          busy,
    output llm_int_pkg::acc_vec_t         out_data,
    output logic                          out_valid,
    input  wire logic                     out_ready
);

    import llm_int_pkg::*;

    localparam int HP_W = 2 * `LLM_ORIG_PREC;
    localparam int LP_W = 2 * `LLM_RED_PREC;

    logic signed [HP_W-1:0] hp_d [`LLM_DIM][`LLM_DIM];
    logic signed [LP_W-1:0] lp_d [`LLM_DIM][`LLM_DIM];
    logic signed [HP_W-1:0] hp_q [`LLM_DIM][`LLM_DIM];
    logic signed [LP_W-1:0] lp_q [`LLM_DIM][`LLM_DIM];
    acc_vec_t               sum_d;

    logic s1_valid;
    logic advance;
    logic take;

    // both stages move together, a stalled output freezes the whole pipe
    assign advance  = !out_valid || out_ready;
    assign in_ready = loaded && advance;
    assign take     = in_valid && in_ready;
    assign busy     = s1_valid || out_valid;

    // ########################################################################
    // stage 1: per-row products of both lanes
    // ########################################################################

    always_comb begin
        qword_t q_low;
        for (int c = 0; c < `LLM_DIM; c++) begin
            q_low = qword_t'($signed(in_data.low[c]) >>> LLM_QSHIFT);
            for (int r = 0; r < `LLM_DIM; r++) begin
                hp_d[r][c] = $signed(in_data.high[c]) * $signed(weights.full[r][c]);
                lp_d[r][c] = q_low * $signed(weights.quant[r][c]);
            end
        end
    end

    // ########################################################################
    // stage 2: row sums, rescale of the low lane and gather
    // ########################################################################

    always_comb begin
        acc_t hsum;
        acc_t lsum;
        for (int r = 0; r < `LLM_DIM; r++) begin
            hsum = '0;
            lsum = '0;
            for (int c = 0; c < `LLM_DIM; c++) begin
                hsum = hsum + hp_q[r][c];
                lsum = lsum + lp_q[r][c];
            end
            // both factors lost QSHIFT bits, so the low sum moves back by twice that
            sum_d[r] = hsum + (lsum <<< (2 * LLM_QSHIFT));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= take;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hp_q <= hp_d;
            lp_q <= lp_d;
        end
        if (advance && s1_valid) begin
            out_data <= sum_d;
        end
    end

    // every vector in the pipe was admitted against a loaded weight set
    a_loaded_first: assert property (
        @(posedge clk) disable iff (!rst_n)
        s1_valid |-> loaded
    ) else $error("mixed_linear: vector entered before weights were loaded");

    // the weight store must not swap the matrix under a vector in flight
    a_weights_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |=> $stable(weights)
    ) else $error("mixed_linear: weights changed while busy");

endmodule

`default_nettype wire

// ==== llm_int_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "llm_int_cfg.svh"

module llm_int_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire llm_int_pkg::vec_t     data_in,
    input  wire logic                  data_in_valid,
    output logic                       data_in_ready,
    input  wire llm_int_pkg::wmat_t    weight_in,
    input  wire logic                  weight_valid,
    output logic                       weight_ready,
    output llm_int_pkg::acc_vec_t      data_out,
    output logic                       data_out_valid,
    input  wire logic                  data_out_ready
);

    import llm_int_pkg::*;

    // scatter to first buffer
    split_t      scat_data;
    logic        scat_valid;
    logic        scat_ready;

    // first buffer to the consumer
    split_t      lin_in_data;
    logic        lin_in_valid;
    logic        lin_in_ready;

    // weight store and consumer sideband
    weight_set_t weights;
    logic        loaded;
    logic        busy;

    // consumer to output buffer
    acc_vec_t    lin_out_data;
    logic        lin_out_valid;
    logic        lin_out_ready;

    outlier_scatter u_scatter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (data_in),
        .in_valid  (data_in_valid),
        .in_ready  (data_in_ready),
        .out_data  (scat_data),
        .out_valid (scat_valid),
        .out_ready (scat_ready)
    );

    stream_fifo #(
        .payload_t (split_t),
        .DEPTH     (`LLM_FIFO_DEPTH)
    ) u_split_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (scat_data),
        .in_valid  (scat_valid),
        .in_ready  (scat_ready),
        .out_data  (lin_in_data),
        .out_valid (lin_in_valid),
        .out_ready (lin_in_ready)
    );

    weight_store u_weights (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_data  (weight_in),
        .w_valid (weight_valid),
        .w_ready (weight_ready),
        .busy    (busy),
        .weights (weights),
        .loaded  (loaded)
    );

    mixed_linear u_linear (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (lin_in_data),
        .in_valid  (lin_in_valid),
        .in_ready  (lin_in_ready),
        .weights   (weights),
        .loaded    (loaded),
        .busy      (busy),
        .out_data  (lin_out_data),
        .out_valid (lin_out_valid),
        .out_ready (lin_out_ready)
    );

    stream_fifo #(
        .payload_t (acc_vec_t),
        .DEPTH     (`LLM_FIFO_DEPTH)
    ) u_result_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (lin_out_data),
        .in_valid  (lin_out_valid),
        .in_ready  (lin_out_ready),
        .out_data  (data_out),
        .out_valid (data_out_valid),
        .out_ready (data_out_ready)
    );

endmodule

`default_nettype wire

// ==== tb_llm_int.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "llm_int_cfg.svh"

module tb_llm_int;

    import llm_int_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] SEED       = 32'hf38c;
    localparam int          LATENCY    = 5;
    localparam int          STEP_LIMIT = 200;

    // the watchdog allows twice the cycle budget of reset and all tests in order
    localparam int RUN_CYCLES  = 16 + 30 + 60 + 20 + 150 + 80 + 20;
    localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

    logic     clk = 1'b0;
    logic     rst_n;
    vec_t     data_in;
    logic     data_in_valid;
    logic     data_in_ready;
    wmat_t    weight_in;
    logic     weight_valid;
    logic     weight_ready;
    acc_vec_t data_out;
    logic     data_out_valid;
    logic     data_out_ready = 1'b1;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    logic        toggle_ready;

    // model state that the monitor updates on each handshake
    wmat_t    model_w;
    vec_t     exp_q[$];
    acc_vec_t last_out;
    int       n_in;
    int       n_out;
    int       n_w;
    int       cycle;
    int       in_cycle;
    int       out_cycle;
    int       n_mismatch;
    int       n_fail;

    llm_int_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .weight_in      (weight_in),
        .weight_valid   (weight_valid),
        .weight_ready   (weight_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################################################
    // stimulus helpers
    // ########################################################################

    // taps 32, 22, 2 and 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic wmat_t rand_matrix();
        wmat_t m;
        for (int r = 0; r < `LLM_DIM; r++) begin
            for (int c = 0; c < `LLM_DIM; c++) begin
                m[r][c] = word_t'(rand_bits(16));
            end
        end
        return m;
    endfunction

    function automatic vec_t rand_vec();
        vec_t x;
        for (int c = 0; c < `LLM_DIM; c++) begin
            x[c] = word_t'(rand_bits(16));
        end
        return x;
    endfunction

    // expected result straight from the split, quantize and sum rules
    function automatic acc_vec_t ref_result(input vec_t x, input wmat_t w);
        acc_vec_t res;
        longint   hi[`LLM_DIM];
        longint   lo[`LLM_DIM];
        longint   s;
        longint   q;
        int       slots;
        slots = 0;
        for (int c = 0; c < `LLM_DIM; c++) begin
            hi[c] = 0;
            lo[c] = longint'($signed(x[c]));
            if ((lo[c] > `LLM_THRESHOLD || lo[c] < -`LLM_THRESHOLD) &&
                slots < `LLM_HIGH_SLOTS) begin
                hi[c] = lo[c];
                lo[c] = 0;
                slots++;
            end
        end
        for (int r = 0; r < `LLM_DIM; r++) begin
            s = 0;
            q = 0;
            for (int c = 0; c < `LLM_DIM; c++) begin
                s += longint'($signed(w[r][c])) * hi[c];
                q += longint'($signed(w[r][c]) >>> LLM_QSHIFT) * (lo[c] >>> LLM_QSHIFT);
            end
            res[r] = acc_t'(s + (q <<< (2 * LLM_QSHIFT)));
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // all driving tasks start and end on a falling edge
    task automatic send_vec(input vec_t x);
        int start;
        int waited;
        start = n_in;
        waited = 0;
        data_in = x;
        data_in_valid = 1'b1;
        while (n_in == start && waited < STEP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        data_in_valid = 1'b0;
        if (n_in == start) begin
            n_fail++;
            $display("input vector was never accepted, gave up at %0t", $time);
        end
    endtask

    task automatic load_weights(input wmat_t w);
        int start;
        int waited;
        start = n_w;
        waited = 0;
        weight_in = w;
        weight_valid = 1'b1;
        while (n_w == start && waited < STEP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        weight_valid = 1'b0;
        if (n_w == start) begin
            n_fail++;
            $display("weight matrix was never accepted, gave up at %0t", $time);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (n_out != n_in && waited < STEP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (n_out != n_in) begin
            n_fail++;
            $display("%0d results never arrived, gave up at %0t", n_in - n_out, $time);
        end
    endtask

    // ########################################################################
    // monitor and ready driver
    // ########################################################################

    always @(posedge clk) begin
        vec_t x;
        cycle++;
        if (weight_valid && weight_ready) begin
            model_w = weight_in;
            n_w++;
        end
        if (data_in_valid && data_in_ready) begin
            exp_q.push_back(data_in);
            in_cycle = cycle;
            n_in++;
        end
        if (data_out_valid && data_out_ready) begin
            out_cycle = cycle;
            last_out = data_out;
            n_out++;
            if (exp_q.size() == 0) begin
                n_fail++;
                $display("result at %0t arrived with no vector outstanding", $time);
            end else begin
                x = exp_q.pop_front();
                check_value("data_out", 256'(data_out), 256'(ref_result(x, model_w)));
            end
        end
    end

    always @(negedge clk) begin
        if (toggle_ready) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            data_out_ready = ready_lfsr[0];
        end else begin
            data_out_ready = 1'b1;
        end
    end

    // ########################################################################
    // directed tests
    // ########################################################################

    // the vector offered here waits in the buffer and leaves in the next test
    task automatic test_no_weights();
        vec_t x;
        check_value("data_out_valid", 256'(data_out_valid), 256'(0));
        x = {16'sd25, -16'sd700, 16'sd999, 16'sd4};
        send_vec(x);
        repeat (20) begin
            @(negedge clk);
            check_value("data_out_valid", 256'(data_out_valid), 256'(0));
        end
    endtask

    task automatic test_identity_low_lane();
        wmat_t w;
        vec_t  x;
        acc_t  exp;
        for (int r = 0; r < `LLM_DIM; r++) begin
            for (int c = 0; c < `LLM_DIM; c++) begin
                // scaled so the quantized copy is exactly the identity
                w[r][c] = (r == c) ? word_t'(1 << LLM_QSHIFT) : '0;
            end
        end
        load_weights(w);
        wait_drain();
        for (int v = 0; v < 4; v++) begin
            if (v == 0) begin
                x = {16'sd1000, -16'sd1000, 16'sd517, -16'sd3};
            end else begin
                for (int c = 0; c < `LLM_DIM; c++) begin
                    x[c] = word_t'(int'(rand_bits(10)) - 512);
                end
            end
            send_vec(x);
            wait_drain();
            for (int r = 0; r < `LLM_DIM; r++) begin
                exp = acc_t'($signed(x[r]) >>> LLM_QSHIFT) <<< (2 * LLM_QSHIFT);
                check_value($sformatf("data_out[%0d]", r), 256'(last_out[r]), 256'(exp));
            end
        end
    endtask

    task automatic test_three_outliers();
        vec_t x;
        load_weights(rand_matrix());
        // outliers at 0, 1 and 3; the one at 3 has no slot left
        x = {16'sd3000, 16'sd300, -16'sd2000, 16'sd1500};
        send_vec(x);
        wait_drain();
    endtask

    task automatic test_backpressure_stream();
        int base_out;
        base_out = n_out;
        toggle_ready = 1'b1;
        for (int v = 0; v < 20; v++) begin
            send_vec(rand_vec());
        end
        wait_drain();
        toggle_ready = 1'b0;
        @(negedge clk);
        check_value("result count", 256'(n_out - base_out), 256'(20));
        check_value("pending results", 256'(exp_q.size()), 256'(0));
    endtask

    task automatic test_weight_reload();
        for (int b = 0; b < 2; b++) begin
            load_weights(rand_matrix());
            for (int v = 0; v < 4; v++) begin
                send_vec(rand_vec());
            end
            // the first vectors of the batch are now inside the consumer
            check_value("weight_ready", 256'(weight_ready), 256'(0));
            wait_drain();
            check_value("weight_ready", 256'(weight_ready), 256'(1));
        end
    endtask

    task automatic test_latency();
        send_vec(rand_vec());
        wait_drain();
        check_value("latency", 256'(out_cycle - in_cycle), 256'(LATENCY));
    endtask

    // ########################################################################
    // run control
    // ########################################################################

    initial begin
        rst_n = 1'b0;
        data_in = '0;
        data_in_valid = 1'b0;
        weight_in = '0;
        weight_valid = 1'b0;
        toggle_ready = 1'b0;
        stim_lfsr = SEED;
        ready_lfsr = SEED;
        n_in = 0;
        n_out = 0;
        n_w = 0;
        cycle = 0;
        in_cycle = 0;
        out_cycle = 0;
        n_mismatch = 0;
        n_fail = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_no_weights();
        test_identity_low_lane();
        test_three_outliers();
        test_backpressure_stream();
        test_weight_reload();
        test_latency();

        $display("checks done: %0d mismatches, %0d other failures", n_mismatch, n_fail);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
llm_int_pkg.sv
outlier_scatter.sv
stream_fifo.sv
weight_store.sv
mixed_linear.sv
llm_int_top.sv
tb_llm_int.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_llm_int \
    -Mdir obj_dir -o sim_llm_int
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_llm_int)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
